// ==== float_unit.f ====
hw/float_pkg.sv
hw/mant_mul_step.sv
hw/float_mul.sv
hw/float_add.sv
hw/float_unit.sv
test/float_unit_tb.sv

// ==== hw/float_add.sv ====
// --------------------------------------------------
// Multi-cycle truncating float adder with bit-serial
// alignment and normalization
// --------------------------------------------------
module float_add
    import float_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  logic [float_width-1:0] a,
    input  logic [float_width-1:0] b,
    output logic                   ack,
    output logic [float_width-1:0] out
);

    e_add_state                 state, n_state;

    logic [float_exp_width-1:0] a_exp_in, b_exp_in;

    logic                       a_sign, n_a_sign;
    logic                       b_sign, n_b_sign;
    logic [float_exp_width-1:0] a_exp, n_a_exp;
    logic [float_exp_width-1:0] b_exp, n_b_exp;
    logic [float_mant_width:0]  a_mant, n_a_mant;  // Hidden one on top
    logic [float_mant_width:0]  b_mant, n_b_mant;

    logic [float_mant_width+1:0] sum, n_sum;  // Extra bit for carry-out
    logic [float_exp_width-1:0]  res_exp, n_res_exp;
    logic                        res_sign, n_res_sign;

    logic                       n_ack;
    logic [float_width-1:0]     n_out;

    assign a_exp_in = a[float_width-2 -: float_exp_width];
    assign b_exp_in = b[float_width-2 -: float_exp_width];

    always_comb begin
        n_state    = state;
        n_a_sign   = a_sign;
        n_b_sign   = b_sign;
        n_a_exp    = a_exp;
        n_b_exp    = b_exp;
        n_a_mant   = a_mant;
        n_b_mant   = b_mant;
        n_sum      = sum;
        n_res_exp  = res_exp;
        n_res_sign = res_sign;
        n_ack      = 1'b0;
        n_out      = '0;

        case (state)
            ADD_IDLE: begin
                if (req) begin
                    if (a_exp_in == '0) begin
                        n_out = b;  // a counts as zero
                        n_ack = 1'b1;
                    end else if (b_exp_in == '0) begin
                        n_out = a;
                        n_ack = 1'b1;
                    end else begin
                        n_a_sign = a[float_width-1];
                        n_b_sign = b[float_width-1];
                        n_a_exp  = a_exp_in;
                        n_b_exp  = b_exp_in;
                        n_a_mant = {1'b1, a[float_mant_width-1:0]};
                        n_b_mant = {1'b1, b[float_mant_width-1:0]};
                        n_state  = ALIGN;
                    end
                end
            end
            ALIGN: begin
                // Once a mantissa has run out, jump straight to the other exponent
                if (a_exp < b_exp) begin
                    n_a_mant = a_mant >> 1;
                    n_a_exp  = (a_mant == '0) ? b_exp : a_exp + float_exp_width'(1);
                end else if (b_exp < a_exp) begin
                    n_b_mant = b_mant >> 1;
                    n_b_exp  = (b_mant == '0) ? a_exp : b_exp + float_exp_width'(1);
                end else begin
                    n_state = SUM;
                end
            end
            SUM: begin
                n_res_exp = a_exp;
                if (a_sign == b_sign) begin
                    n_sum      = {1'b0, a_mant} + {1'b0, b_mant};
                    n_res_sign = a_sign;
                end else if (a_mant >= b_mant) begin
                    n_sum      = {1'b0, a_mant} - {1'b0, b_mant};
                    n_res_sign = a_sign;
                end else begin
                    n_sum      = {1'b0, b_mant} - {1'b0, a_mant};
                    n_res_sign = b_sign;
                end
                if (n_sum == '0) begin
                    n_ack   = 1'b1;  // Full cancellation gives +0
                    n_state = ADD_IDLE;
                end else begin
                    n_state = NORM;
                end
            end
            NORM: begin
                if (sum[float_mant_width+1]) begin
                    n_sum     = sum >> 1;  // Carry-out
                    n_res_exp = res_exp + float_exp_width'(1);
                end else if (!sum[float_mant_width]) begin
                    n_sum     = sum << 1;
                    n_res_exp = res_exp - float_exp_width'(1);
                end else begin
                    n_out   = {res_sign, res_exp, sum[float_mant_width-1:0]};
                    n_ack   = 1'b1;
                    n_state = ADD_IDLE;
                end
            end
            default: begin
                n_state = ADD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ADD_IDLE;
            ack   <= 1'b0;
            out   <= '0;
        end else begin
            state <= n_state;
            ack   <= n_ack;
            out   <= n_out;
        end
    end

    always_ff @(posedge clk) begin
        a_sign   <= n_a_sign;
        b_sign   <= n_b_sign;
        a_exp    <= n_a_exp;
        b_exp    <= n_b_exp;
        a_mant   <= n_a_mant;
        b_mant   <= n_b_mant;
        sum      <= n_sum;
        res_exp  <= n_res_exp;
        res_sign <= n_res_sign;
    end

endmodule

// ==== hw/float_mul.sv ====
// --------------------------------------------------
// Multi-cycle truncating float multiplier with
// denormal flush and a 2 bit per cycle mantissa product
// --------------------------------------------------
module float_mul
    import float_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  logic [float_width-1:0] a,
    input  logic [float_width-1:0] b,
    output logic                   ack,
    output logic [float_width-1:0] out
);

    e_mul_state                 state, n_state;

    logic [float_exp_width-1:0] a_exp_in, b_exp_in;

    logic [float_mant_width:0]  a_mant, n_a_mant;  // Hidden one on top
    logic [float_mant_width:0]  b_mant, n_b_mant;
    logic [float_exp_width+1:0] new_exp, n_new_exp;  // Two guard bits for the bias math
    logic                       new_sign, n_new_sign;

    // Full product plus room for the last column pair
    logic [2*float_mant_width+3:0] prod, n_prod;

    logic [mul_pos_width-1:0]   pos, n_pos;
    logic [mul_pos_width-1:0]   norm_pos, n_norm_pos;  // Highest one seen so far
    logic [mul_pos_width-1:0]   shift;
    logic [mul_carry_width-1:0] carry, n_carry, step_carry;
    logic [bits_per_cycle-1:0]  step_bits;

    logic                       n_ack;
    logic [float_width-1:0]     n_out;

    assign a_exp_in = a[float_width-2 -: float_exp_width];
    assign b_exp_in = b[float_width-2 -: float_exp_width];

    // Right shift that leaves the leading one at bit 23
    assign shift = norm_pos - mul_pos_width'(float_mant_width);

    mant_mul_step i_mant_mul_step (
        .pos       (pos),
        .a_mant    (a_mant),
        .b_mant    (b_mant),
        .carry_in  (carry),
        .prod_bits (step_bits),
        .carry_out (step_carry)
    );

    always_comb begin
        n_state    = state;
        n_a_mant   = a_mant;
        n_b_mant   = b_mant;
        n_new_exp  = new_exp;
        n_new_sign = new_sign;
        n_prod     = prod;
        n_pos      = pos;
        n_norm_pos = norm_pos;
        n_carry    = carry;
        n_ack      = 1'b0;
        n_out      = '0;

        case (state)
            MUL_IDLE: begin
                if (req) begin
                    if (a_exp_in == '0 || b_exp_in == '0) begin
                        n_ack = 1'b1;  // Zero or denormal gives +0
                    end else begin
                        n_a_mant   = {1'b1, a[float_mant_width-1:0]};
                        n_b_mant   = {1'b1, b[float_mant_width-1:0]};
                        n_new_sign = a[float_width-1] ^ b[float_width-1];
                        // Exponent of product bit 0
                        n_new_exp  = (float_exp_width + 2)'(int'(a_exp_in) + int'(b_exp_in)
                                     - float_bias - float_mant_width);
                        n_prod     = '0;
                        n_pos      = '0;
                        n_norm_pos = '0;
                        n_carry    = '0;
                        n_state    = MUL1;
                    end
                end
            end
            MUL1: begin
                n_prod[pos +: bits_per_cycle] = step_bits;
                n_carry = step_carry;
                for (int k = 0; k < bits_per_cycle; k++) begin
                    if (step_bits[k]) begin
                        n_norm_pos = pos + mul_pos_width'(k);
                    end
                end
                n_pos = pos + mul_pos_width'(bits_per_cycle);
                if (pos >= mul_pos_width'(2 * float_mant_width + 2)) begin
                    n_state = S2;  // Last column pair done
                end
            end
            S2: begin
                n_prod    = prod >> shift;
                n_new_exp = new_exp + (float_exp_width + 2)'(shift);
                n_out     = {new_sign, n_new_exp[float_exp_width-1:0],
                             n_prod[float_mant_width-1:0]};
                n_ack     = 1'b1;
                n_state   = MUL_IDLE;
            end
            default: begin
                n_state = MUL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MUL_IDLE;
            ack   <= 1'b0;
            out   <= '0;
        end else begin
            state <= n_state;
            ack   <= n_ack;
            out   <= n_out;
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        a_mant   <= n_a_mant;
        b_mant   <= n_b_mant;
        new_exp  <= n_new_exp;
        new_sign <= n_new_sign;
        prod     <= n_prod;
        pos      <= n_pos;
        norm_pos <= n_norm_pos;
        carry    <= n_carry;
    end

endmodule

// ==== hw/float_pkg.sv ====
// --------------------------------------------------
// Float unit package: IEEE-754 single format widths,
// multiplier step sizes, opcode and state encodings
// --------------------------------------------------
package float_pkg;

    // Single-precision layout
    localparam int float_width      = 32;
    localparam int float_exp_width  = 8;
    localparam int float_mant_width = 23;  // Stored bits, hidden one excluded
    localparam int float_bias       = 127;

    // Column-wise mantissa multiply
    localparam int bits_per_cycle  = 2;  // Product bits formed per cycle
    localparam int mul_carry_width = 5;  // Column carry, peaks near 24
    localparam int mul_pos_width   = 6;  // Column index up to 49

    // Opcode as used by the requester and the data file
    typedef enum logic {
        OP_MUL = 1'b0,
        OP_ADD = 1'b1
    } e_fpu_op;

    // Multiplier FSM
    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL1,  // Two product bits per cycle
        S2     // Normalize and pack
    } e_mul_state;

    // Adder FSM
    typedef enum logic [1:0] {
        ADD_IDLE,
        ALIGN,  // Match exponents one bit per cycle
        SUM,
        NORM    // Move hidden one back to bit 23
    } e_add_state;

endpackage

// ==== hw/float_unit.sv ====
// --------------------------------------------------
// Float unit top, one operation in flight, dispatches
// to the multiplier or adder by opcode
// --------------------------------------------------
module float_unit
    import float_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  e_fpu_op                op,
    input  logic [float_width-1:0] a,
    input  logic [float_width-1:0] b,
    output logic                   ack,
    output logic [float_width-1:0] out,
    output logic                   busy
);

    e_fpu_op                op_q;  // Operation in flight
    logic [float_width-1:0] a_q, b_q;

    logic                   mul_req, add_req;
    logic                   mul_ack, add_ack;
    logic [float_width-1:0] mul_out, add_out;

    logic                   unit_ack;
    logic [float_width-1:0] unit_out;

    // Only the selected unit's answer counts
    assign unit_ack = busy & ((op_q == OP_MUL) ? mul_ack : add_ack);
    assign unit_out = (op_q == OP_MUL) ? mul_out : add_out;

    float_mul i_float_mul (
        .clk (clk),
        .rst (rst),
        .req (mul_req),
        .a   (a_q),
        .b   (b_q),
        .ack (mul_ack),
        .out (mul_out)
    );

    float_add i_float_add (
        .clk (clk),
        .rst (rst),
        .req (add_req),
        .a   (a_q),
        .b   (b_q),
        .ack (add_ack),
        .out (add_out)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_q    <= OP_MUL;
            busy    <= 1'b0;
            mul_req <= 1'b0;
            add_req <= 1'b0;
            ack     <= 1'b0;
            out     <= '0;
        end else begin
            mul_req <= 1'b0;
            add_req <= 1'b0;
            ack     <= unit_ack;
            out     <= unit_ack ? unit_out : '0;
            if (req && !busy) begin
                busy    <= 1'b1;
                op_q    <= op;
                mul_req <= (op == OP_MUL);
                add_req <= (op == OP_ADD);
            end else if (unit_ack) begin
                busy <= 1'b0;
            end
        end
    end

    // Operands held for the unit's req cycle
    always_ff @(posedge clk) begin
        if (req && !busy) begin
            a_q <= a;
            b_q <= b;
        end
    end

endmodule

// ==== hw/mant_mul_step.sv ====
// --------------------------------------------------
// One column step of the 24x24 mantissa multiply,
// two product bits and the carry into the next pair
// --------------------------------------------------
module mant_mul_step
    import float_pkg::*;
(
    input  logic [mul_pos_width-1:0]   pos,
    input  logic [float_mant_width:0]  a_mant,
    input  logic [float_mant_width:0]  b_mant,
    input  logic [mul_carry_width-1:0] carry_in,
    output logic [bits_per_cycle-1:0]  prod_bits,
    output logic [mul_carry_width-1:0] carry_out
);

    // Each column adds every a[i]*b[j] with i+j equal to the column,
    // on top of what spilled over from the column below
    always_comb begin
        logic [mul_carry_width+1:0] acc;
        int col;
        int j;

        acc = (mul_carry_width + 2)'(carry_in);
        for (int k = 0; k < bits_per_cycle; k++) begin
            col = int'(pos) + k;
            for (int i = 0; i <= float_mant_width; i++) begin
                j = col - i;
                // Only pairs that fall inside b
                if (j >= 0 && j <= float_mant_width) begin
                    acc = acc + (mul_carry_width + 2)'(a_mant[i] & b_mant[j]);
                end
            end
            prod_bits[k] = acc[0];  // Column result
            acc = acc >> 1;         // Rest moves up one column
        end
        carry_out = acc[mul_carry_width-1:0];
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the float unit testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module float_unit_tb \
    -Mdir obj_dir -o float_unit_sim -f float_unit.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/float_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== test/float_unit_tb.sv ====
// --------------------------------------------------
// Float unit testbench, file driven vectors with ack
// timing, busy drop and idle output checks
// --------------------------------------------------
module float_unit_tb
    import float_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk;
    logic                   rst;
    logic                   req;
    e_fpu_op                op;
    logic [float_width-1:0] a;
    logic [float_width-1:0] b;
    logic                   ack;
    logic [float_width-1:0] out;
    logic                   busy;

    int          mismatches;
    int          timeouts;
    int          file_errors;
    int          vec_count;
    int          fd;
    int          code;
    int          fields;
    bit          stop_run;
    string       line;
    logic [3:0]  vec_op;
    logic [31:0] vec_a, vec_b, vec_exp;

    float_unit i_float_unit (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .op   (op),
        .a    (a),
        .b    (b),
        .ack  (ack),
        .out  (out),
        .busy (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h, actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    // Edges from accepted req to ack, zero when not fixed
    function automatic int fixed_latency(input logic is_add, input logic [31:0] x,
                                         input logic [31:0] y);
        if (x[30:23] == 8'd0 || y[30:23] == 8'd0) begin
            return 2;  // Unit answers on its req edge
        end
        if (!is_add) begin
            return 28;  // Unit req, 25 steps, normalize, top ack
        end
        return 0;
    endfunction

    task automatic check_idle(input string name);
        check_value({name, " ack"}, 32'd0, {31'd0, ack});
        check_value({name, " busy"}, 32'd0, {31'd0, busy});
        check_value({name, " out"}, 32'd0, out);
    endtask

    task automatic apply_vector();
        string name;
        int    edges;
        int    lat_exp;
        int    extra_acks;
        bit    got_ack;

        name = $sformatf("vector %0d %s", vec_count, vec_op[0] ? "add" : "mul");
        vec_count++;
        req = 1'b1;
        op  = vec_op[0] ? OP_ADD : OP_MUL;
        a   = vec_a;
        b   = vec_b;
        edges   = 0;
        got_ack = 1'b0;
        while (!got_ack && edges < 200) begin
            @(negedge clk);
            edges++;
            if (edges == 1) begin
                check_value({name, " busy"}, 32'd1, {31'd0, busy});
                // Stray request while busy
                op = vec_op[0] ? OP_MUL : OP_ADD;
                a  = 32'h3f800000;
                b  = 32'h40400000;
            end else begin
                req = 1'b0;
            end
            got_ack = ack;
        end
        req = 1'b0;

        if (!got_ack) begin
            $display("Timed out after 200 cycles waiting for ack on %s", name);
            timeouts++;
            stop_run = 1'b1;
        end else begin
            check_value({name, " result"}, vec_exp, out);
            check_value({name, " busy at ack"}, 32'd0, {31'd0, busy});
            lat_exp = fixed_latency(vec_op[0], vec_a, vec_b);
            if (lat_exp != 0) begin
                check_value({name, " latency"}, 32'(lat_exp), 32'(edges - 1));
            end
            @(negedge clk);
            check_idle({name, " after ack"});
            // Long enough for a second multiply to come back
            extra_acks = 0;
            repeat (40) begin
                @(negedge clk);
                if (ack) begin
                    extra_acks++;
                end
            end
            check_value({name, " extra acks"}, 32'd0, 32'(extra_acks));
        end
    endtask

    initial begin
        rst  = 1'b1;
        req  = 1'b0;
        op   = OP_MUL;
        a    = '0;
        b    = '0;
        mismatches  = 0;
        timeouts    = 0;
        file_errors = 0;
        vec_count   = 0;
        stop_run    = 1'b0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        check_idle("in reset");
        rst = 1'b0;
        @(negedge clk);
        check_idle("after reset");

        fd = $fopen("test/float_unit_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file test/float_unit_testdata.txt");
            file_errors++;
        end else begin
            while (!$feof(fd) && !stop_run) begin
                code = $fgets(line, fd);
                // Skip comments and blank lines
                if (code > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                    fields = $sscanf(line, "%h %h %h %h", vec_op, vec_a, vec_b, vec_exp);
                    if (fields == 4) begin
                        apply_vector();
                    end else begin
                        $display("Malformed line in the test data file: %s", line);
                        file_errors++;
                    end
                end
            end
            $fclose(fd);
            if (vec_count == 0) begin
                $display("The test data file holds no vectors");
                file_errors++;
            end
        end

        $display("Summary: %0d vectors, %0d mismatches, %0d timeouts, %0d file errors",
                 vec_count, mismatches, timeouts, file_errors);
        if (mismatches == 0 && timeouts == 0 && file_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== test/float_unit_testdata.txt ====
// Columns: op a b expected, all hex, expected is truncated with denormals as zero
// op 0 is multiply, op 1 is add
0 3fc00000 40000000 40400000
0 c0400000 3f000000 bfc00000
0 c0200000 c0800000 41200000
0 3f8ccccd 40400000 40533333
0 bf8ccccd 40400000 c0533333
0 3dcccccd 41200000 3f800000
0 3fffffff 3fffffff 407ffffe
0 3f800001 3f800001 3f800002
0 00000000 40400000 00000000
0 00400000 3f800000 00000000
0 80000000 c0000000 00000000
0 3f800000 00000001 00000000
1 3fc00000 3fc00000 40400000
1 3f800000 40000000 40400000
1 3f800000 3e800000 3fa00000
1 3f800000 3f800001 40000000
1 3fffffff 3f800000 403fffff
1 40400000 3f8ccccd 40833333
1 c0000000 c0400000 c0a00000
1 40000000 c0000000 00000000
1 40400000 bf800000 40000000
1 3f800000 bf800001 b4000000
1 3fc00000 bfa00000 3e800000
1 c0800000 3f800000 c0400000
1 40000000 bf8ccccd 3f666668
1 00000000 40400000 40400000
1 c0a00000 00000000 c0a00000
1 00400000 bf800000 bf800000
